/* hdl/bpred_cfg.svh */
`ifndef BPRED_CFG_SVH
`define BPRED_CFG_SVH

// Branch predictor sizing

// Width of a PC or a branch target
`define BP_XLEN 32

// Sets held by each way
`define BP_SETS 16

// Index bits, log2 of the set count
`define BP_INDEX_W 4

// Ways per set
`define BP_WAYS 4

// PC bits above the index and the two byte-offset bits
`define BP_TAG_W 26

`endif

/* hdl/rv_addr_pkg.sv */
`include "bpred_cfg.svh"

package rv_addr_pkg;

  // Instructions are word aligned
  // Low PC bits below the set index
  localparam int PC_OFS_W = 2;

  // Fetch PC, update PC or branch target
  typedef logic [`BP_XLEN-1:0] pc_t;

  // Set index
  // Taken from the PC bits just above the byte offset
  typedef logic [`BP_INDEX_W-1:0] btb_index_t;

  // Tag stored with each entry
  // All PC bits above the index
  typedef logic [`BP_TAG_W-1:0] btb_tag_t;

endpackage

/* hdl/bpred_state_pkg.sv */
`include "bpred_cfg.svh"

package bpred_state_pkg;

  // Two-bit saturating direction counter
  // Training moves one step toward the branch outcome
  // The upper two states predict taken
  typedef enum logic [1:0] {
    strong_nt = 2'b00,
    weak_nt   = 2'b01,
    weak_t    = 2'b10,
    strong_t  = 2'b11
  } bp_ctr_e;

  // One bit per way
  // Carries lookup hits, update matches and write enables
  typedef logic [`BP_WAYS-1:0] way_vec_t;

endpackage

/* hdl/btb_index.sv */
`timescale 1ns/10ps
`include "bpred_cfg.svh"

module btb_index
  import rv_addr_pkg::*;
  import bpred_state_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  pc_t        fetch_pc,
  input  pc_t        upd_pc,
  input  logic       upd_valid,
  input  logic       upd_taken,
  input  way_vec_t   upd_match,
  output btb_index_t lk_index,
  output btb_index_t upd_index,
  output btb_tag_t   lk_tag,
  output btb_tag_t   upd_tag,
  output way_vec_t   way_we
);

  // Victim pointer width, enough to name any way
  localparam int VIC_W = (`BP_WAYS > 1) ? $clog2(`BP_WAYS) : 1;

  // Round-robin victim pointer per set
  logic [VIC_W-1:0] victim_q [`BP_SETS];
  logic [VIC_W-1:0] victim_cur;
  logic             alloc;

  // PC split for the lookup and for the update
  assign lk_index  = fetch_pc[PC_OFS_W +: `BP_INDEX_W];
  assign lk_tag    = fetch_pc[`BP_XLEN-1 -: `BP_TAG_W];
  assign upd_index = upd_pc[PC_OFS_W +: `BP_INDEX_W];
  assign upd_tag   = upd_pc[`BP_XLEN-1 -: `BP_TAG_W];

  // Pointer of the set being updated
  assign victim_cur = victim_q[upd_index];

  // Taken miss claims the victim way
  // Not-taken misses leave the set alone
  assign alloc = upd_valid && upd_taken && (upd_match == '0);

  always_comb begin
    way_we = '0;
    if (upd_valid) begin
      if (upd_match != '0) begin
        // Existing entry gets trained
        way_we = upd_match;
      end else if (upd_taken) begin
        way_we[victim_cur] = 1'b1;
      end
    end
  end

  // Advance the set's pointer after each allocation, wrapping at the last way
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int s = 0; s < `BP_SETS; s++) begin
        victim_q[s] <= '0;
      end
    end else if (alloc) begin
      if (victim_cur == VIC_W'(`BP_WAYS - 1)) begin
        victim_q[upd_index] <= '0;
      end else begin
        victim_q[upd_index] <= victim_cur + 1'b1;
      end
    end
  end

  // At most one way is written per update
  a_we_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(way_we))
    else $error("btb_index: write enable %b is not one-hot", way_we);

endmodule

/* hdl/btb_way.sv */
`timescale 1ns/10ps
`include "bpred_cfg.svh"

module btb_way
  import rv_addr_pkg::*;
  import bpred_state_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  btb_index_t lk_index,
  input  btb_index_t upd_index,
  input  btb_tag_t   lk_tag,
  input  btb_tag_t   upd_tag,
  input  logic       we,
  input  logic       upd_taken,
  input  pc_t        upd_target,
  output logic       lk_hit,
  output logic       lk_taken,
  output logic       upd_match,
  output pc_t        lk_target
);

  // Entry storage, one slot per set
  logic     valid_q  [`BP_SETS];
  btb_tag_t tag_q    [`BP_SETS];
  pc_t      target_q [`BP_SETS];
  bp_ctr_e  ctr_q    [`BP_SETS];

  // Counters read at the lookup and update indices
  bp_ctr_e  lk_ctr;
  bp_ctr_e  upd_ctr;

  // One saturating step toward the outcome
  function automatic bp_ctr_e ctr_step(input bp_ctr_e cur, input logic taken);
    bp_ctr_e nxt;
    case (cur)
      strong_nt: nxt = taken ? weak_nt  : strong_nt;
      weak_nt:   nxt = taken ? weak_t   : strong_nt;
      weak_t:    nxt = taken ? strong_t : weak_nt;
      strong_t:  nxt = taken ? strong_t : weak_t;
      default:   nxt = weak_t;
    endcase
    return nxt;
  endfunction

  // Lookup path, purely combinational
  assign lk_ctr    = ctr_q[lk_index];
  assign lk_hit    = valid_q[lk_index] && (tag_q[lk_index] == lk_tag);
  // Taken only when the entry is really there
  assign lk_taken  = lk_hit && ((lk_ctr == weak_t) || (lk_ctr == strong_t));
  assign lk_target = target_q[lk_index];

  // Update path compare
  assign upd_ctr   = ctr_q[upd_index];
  assign upd_match = valid_q[upd_index] && (tag_q[upd_index] == upd_tag);

  // Valid bits
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int s = 0; s < `BP_SETS; s++) begin
        valid_q[s] <= 1'b0;
      end
    end else if (we) begin
      valid_q[upd_index] <= 1'b1;
    end
  end

  // Tag, target and counter
  // Written at the edge ending the strobe, so same-cycle lookups see old data
  always_ff @(posedge clk) begin
    if (we) begin
      if (upd_match) begin
        // Train the resident entry
        ctr_q[upd_index] <= ctr_step(upd_ctr, upd_taken);
        // Keep the old target on a not-taken outcome
        if (upd_taken) begin
          target_q[upd_index] <= upd_target;
        end
      end else begin
        // Fresh allocation starts weakly taken
        tag_q[upd_index]    <= upd_tag;
        target_q[upd_index] <= upd_target;
        ctr_q[upd_index]    <= weak_t;
      end
    end
  end

endmodule

/* hdl/btb_select.sv */
`timescale 1ns/10ps
`include "bpred_cfg.svh"

module btb_select
  import rv_addr_pkg::*;
  import bpred_state_pkg::*;
(
  input  way_vec_t           lk_hit_vec,
  input  way_vec_t           lk_taken_vec,
  input  pc_t [`BP_WAYS-1:0] lk_target_vec,
  output logic               hit_if,
  output logic               taken_if,
  output pc_t                target_if
);

  // Any way hitting means a BTB hit
  assign hit_if = |lk_hit_vec;

  // Priority mux
  // Scan from the top way down so the lowest hit is the last to write
  always_comb begin
    taken_if  = 1'b0;
    target_if = '0;
    for (int i = `BP_WAYS - 1; i >= 0; i--) begin
      if (lk_hit_vec[i]) begin
        taken_if  = lk_taken_vec[i];
        target_if = lk_target_vec[i];
      end
    end
  end

  // Allocation only happens on a miss, so a PC lives in at most one way
  // Skipped while the ways are still unknown before reset
  always_comb begin
    if (!$isunknown(lk_hit_vec)) begin
      a_single_hit: assert final ($onehot0(lk_hit_vec))
        else $error("btb_select: several ways hit, vector %b", lk_hit_vec);
    end
  end

endmodule

/* hdl/bpred_if_buffer.sv */
`timescale 1ns/10ps
`include "bpred_cfg.svh"

module bpred_if_buffer
  import rv_addr_pkg::*;
(
  input  logic clk,
  input  logic rst,
  input  logic if_id_stall,
  input  logic if_id_flush,
  input  logic hit_if,
  input  logic taken_if,
  input  pc_t  target_if,
  output logic hit_id,
  output logic taken_id,
  output pc_t  target_id
);

  // IF/ID copy of the prediction
  // Zero-latency BTB lookup, so the register lives here
  logic hit_q;
  logic taken_q;
  pc_t  target_q;

  always_ff @(posedge clk) begin
    // Flush is checked first and beats stall
    if (rst || if_id_flush) begin
      hit_q    <= 1'b0;
      taken_q  <= 1'b0;
      target_q <= '0;
    end else if (!if_id_stall) begin
      hit_q    <= hit_if;
      taken_q  <= taken_if;
      target_q <= target_if;
    end
  end

  assign hit_id    = hit_q;
  assign taken_id  = taken_q;
  assign target_id = target_q;

  // Flushed slot carries no prediction into ID
  a_flush_clears: assert property (@(posedge clk) disable iff (rst)
    if_id_flush |=> !hit_id)
    else $error("bpred_if_buffer: hit_id set after flush");

  // Stalled stage holds its prediction unless flushed
  a_stall_holds: assert property (@(posedge clk) disable iff (rst)
    (if_id_stall && !if_id_flush) |=> $stable({hit_id, taken_id, target_id}))
    else $error("bpred_if_buffer: ID prediction moved during stall");

endmodule

/* hdl/bpred_top.sv */
`timescale 1ns/10ps
`include "bpred_cfg.svh"

module bpred_top
  import rv_addr_pkg::*;
  import bpred_state_pkg::*;
(
  input  logic clk,
  input  logic rst,
  input  pc_t  fetch_pc,
  input  logic if_id_stall,
  input  logic if_id_flush,
  input  logic upd_valid,
  input  pc_t  upd_pc,
  input  logic upd_taken,
  input  pc_t  upd_target,
  output logic hit_id,
  output logic taken_id,
  output pc_t  target_id
);

  // Index and tag fan-out
  btb_index_t lk_index;
  btb_index_t upd_index;
  btb_tag_t   lk_tag;
  btb_tag_t   upd_tag;

  // Per-way control and results
  way_vec_t           way_we;
  way_vec_t           upd_match;
  way_vec_t           lk_hit_vec;
  way_vec_t           lk_taken_vec;
  pc_t [`BP_WAYS-1:0] lk_target_vec;

  // IF stage prediction
  logic hit_if;
  logic taken_if;
  pc_t  target_if;

  // PC split, victim pointers, write way choice
  btb_index u_index (
    .clk       (clk),
    .rst       (rst),
    .fetch_pc  (fetch_pc),
    .upd_pc    (upd_pc),
    .upd_valid (upd_valid),
    .upd_taken (upd_taken),
    .upd_match (upd_match),
    .lk_index  (lk_index),
    .upd_index (upd_index),
    .lk_tag    (lk_tag),
    .upd_tag   (upd_tag),
    .way_we    (way_we)
  );

  // Ways, all alike
  for (genvar w = 0; w < `BP_WAYS; w++) begin : g_way
    btb_way u_way (
      .clk        (clk),
      .rst        (rst),
      .lk_index   (lk_index),
      .upd_index  (upd_index),
      .lk_tag     (lk_tag),
      .upd_tag    (upd_tag),
      .we         (way_we[w]),
      .upd_taken  (upd_taken),
      .upd_target (upd_target),
      .lk_hit     (lk_hit_vec[w]),
      .lk_taken   (lk_taken_vec[w]),
      .upd_match  (upd_match[w]),
      .lk_target  (lk_target_vec[w])
    );
  end

  // Hit merge
  btb_select u_select (
    .lk_hit_vec    (lk_hit_vec),
    .lk_taken_vec  (lk_taken_vec),
    .lk_target_vec (lk_target_vec),
    .hit_if        (hit_if),
    .taken_if      (taken_if),
    .target_if     (target_if)
  );

  // IF/ID register
  bpred_if_buffer u_if_buf (
    .clk         (clk),
    .rst         (rst),
    .if_id_stall (if_id_stall),
    .if_id_flush (if_id_flush),
    .hit_if      (hit_if),
    .taken_if    (taken_if),
    .target_if   (target_if),
    .hit_id      (hit_id),
    .taken_id    (taken_id),
    .target_id   (target_id)
  );

endmodule

/* verification/tb_bpred_model.svh */
`ifndef TB_BPRED_MODEL_SVH
`define TB_BPRED_MODEL_SVH

// Reference copy of the BTB, indexed by set then way
// Counter kept as 0 to 3, strong not taken up to strong taken
bit       m_valid  [`BP_SETS][`BP_WAYS];
btb_tag_t m_tag    [`BP_SETS][`BP_WAYS];
pc_t      m_target [`BP_SETS][`BP_WAYS];
int       m_ctr    [`BP_SETS][`BP_WAYS];
int       m_victim [`BP_SETS];

// Set index sits just above the two byte-offset bits
function automatic int pc_set(input pc_t pc);
  return int'(pc[2 +: `BP_INDEX_W]);
endfunction

// Tag is every PC bit above the index
function automatic btb_tag_t pc_tag(input pc_t pc);
  return pc[`BP_XLEN-1 -: `BP_TAG_W];
endfunction

// Way holding pc, or -1 when absent
function automatic int find_way(input pc_t pc);
  int s;
  s = pc_set(pc);
  for (int w = 0; w < `BP_WAYS; w++) begin
    if (m_valid[s][w] && (m_tag[s][w] == pc_tag(pc))) begin
      return w;
    end
  end
  return -1;
endfunction

// Empty BTB, every victim pointer back at way 0
function automatic void model_reset();
  for (int s = 0; s < `BP_SETS; s++) begin
    m_victim[s] = 0;
    for (int w = 0; w < `BP_WAYS; w++) begin
      m_valid[s][w] = 1'b0;
    end
  end
endfunction

// Resolved branch, applied at the edge closing the strobe cycle
function automatic void model_update(input pc_t pc, input logic taken, input pc_t target);
  int s;
  int w;
  s = pc_set(pc);
  w = find_way(pc);
  if (w >= 0) begin
    // Saturating step toward the outcome
    if (taken && (m_ctr[s][w] < 3)) begin
      m_ctr[s][w]++;
    end else if (!taken && (m_ctr[s][w] > 0)) begin
      m_ctr[s][w]--;
    end
    if (taken) begin
      m_target[s][w] = target;
    end
  end else if (taken) begin
    // Taken miss replaces the set's victim, new entry weakly taken
    w = m_victim[s];
    m_valid[s][w]  = 1'b1;
    m_tag[s][w]    = pc_tag(pc);
    m_target[s][w] = target;
    m_ctr[s][w]    = 2;
    m_victim[s]    = (w + 1) % `BP_WAYS;
  end
endfunction

// Expected IF prediction for pc, all zero on a miss
function automatic void predict(input pc_t pc, output logic hit, output logic taken,
                                output pc_t target);
  int s;
  int w;
  s = pc_set(pc);
  w = find_way(pc);
  hit    = (w >= 0);
  taken  = 1'b0;
  target = '0;
  if (w >= 0) begin
    taken  = (m_ctr[s][w] >= 2);
    target = m_target[s][w];
  end
endfunction

`endif

/* verification/tb_bpred_top.sv */
`timescale 1ns/10ps
`include "bpred_cfg.svh"

module tb_bpred_top
  import rv_addr_pkg::*;
();

  logic clk = 1'b0;
  logic rst;
  pc_t  fetch_pc;
  logic if_id_stall;
  logic if_id_flush;
  logic upd_valid;
  pc_t  upd_pc;
  logic upd_taken;
  pc_t  upd_target;
  logic hit_id;
  logic taken_id;
  pc_t  target_id;

  `include "tb_bpred_model.svh"

  // Expected ID stage contents after the next edge
  logic exp_hit;
  logic exp_taken;
  pc_t  exp_target;
  int   n_checked = 0;
  pc_t  pool [12];

  bpred_top dut0 (
    .clk         (clk),
    .rst         (rst),
    .fetch_pc    (fetch_pc),
    .if_id_stall (if_id_stall),
    .if_id_flush (if_id_flush),
    .upd_valid   (upd_valid),
    .upd_pc      (upd_pc),
    .upd_taken   (upd_taken),
    .upd_target  (upd_target),
    .hit_id      (hit_id),
    .taken_id    (taken_id),
    .target_id   (target_id)
  );

  // 8 ns period
  always #4 clk = ~clk;

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("ERR %0t: %s is %b, expected %b", $time, what, got, exp);
      $display("Test FAILED");
      $fatal(1, "flag mismatch");
    end
  endtask

  task automatic check_pc(input pc_t got, input pc_t exp, input string what);
    if (got !== exp) begin
      $display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
      $display("Test FAILED");
      $fatal(1, "pc mismatch");
    end
  endtask

  // Sampled at the falling edge, inputs and outputs both settled
  always @(negedge clk) begin : compare
    logic p_hit;
    logic p_taken;
    pc_t  p_target;
    if (rst) begin
      model_reset();
      exp_hit    = 1'b0;
      exp_taken  = 1'b0;
      exp_target = '0;
    end else begin
      check_flag(hit_id, exp_hit, "hit_id");
      check_flag(taken_id, exp_taken, "taken_id");
      check_pc(target_id, exp_target, "target_id");
      n_checked++;
      // Lookup sees the contents before this cycle's update
      predict(fetch_pc, p_hit, p_taken, p_target);
      if (if_id_flush) begin
        exp_hit    = 1'b0;
        exp_taken  = 1'b0;
        exp_target = '0;
      end else if (!if_id_stall) begin
        exp_hit    = p_hit;
        exp_taken  = p_taken;
        exp_target = p_target;
      end
      if (upd_valid) begin
        model_update(upd_pc, upd_taken, upd_target);
      end
    end
  end

  function automatic pc_t mk_pc(input int tag, input int set);
    return {tag[`BP_TAG_W-1:0], set[`BP_INDEX_W-1:0], 2'b00};
  endfunction

  // One cycle of lookup, no update
  task automatic step(input pc_t pc, input logic stall, input logic flush);
    @(posedge clk);
    fetch_pc    <= pc;
    if_id_stall <= stall;
    if_id_flush <= flush;
    upd_valid   <= 1'b0;
  endtask

  // One update strobe, looking up the same PC
  task automatic train(input pc_t pc, input logic taken, input pc_t tgt);
    @(posedge clk);
    fetch_pc    <= pc;
    if_id_stall <= 1'b0;
    if_id_flush <= 1'b0;
    upd_valid   <= 1'b1;
    upd_pc      <= pc;
    upd_taken   <= taken;
    upd_target  <= tgt;
  endtask

  task automatic expect_id(input logic h, input logic t, input pc_t tgt);
    @(negedge clk);
    check_flag(hit_id, h, "directed hit_id");
    check_flag(taken_id, t, "directed taken_id");
    check_pc(target_id, tgt, "directed target_id");
  endtask

  // Present pc, let the IF/ID register take it, then look at ID
  task automatic probe(input pc_t pc, input logic h, input logic t, input pc_t tgt);
    step(pc, 1'b0, 1'b0);
    @(posedge clk);
    expect_id(h, t, tgt);
  endtask

  task automatic wait_checks(input int n);
    int guard;
    guard = 0;
    while (n_checked < n) begin
      @(posedge clk);
      guard++;
      if (guard > 50) begin
        $display("Timeout: compare process stalled after %0d checks", n_checked);
        $display("Test FAILED");
        $fatal(1, "timeout");
      end
    end
  endtask

  initial begin
    void'($urandom(32'hf468_d4c0));
    rst         <= 1'b1;
    fetch_pc    <= '0;
    if_id_stall <= 1'b0;
    if_id_flush <= 1'b0;
    upd_valid   <= 1'b0;
    upd_pc      <= '0;
    upd_taken   <= 1'b0;
    upd_target  <= '0;
    // Twelve PCs over two sets, six tags each
    for (int i = 0; i < 12; i++) begin
      pool[i] = mk_pc(i + 40, i % 2);
    end
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    wait_checks(1);

    // Empty after reset
    probe(mk_pc(1, 3), 1'b0, 1'b0, '0);
    // Taken miss allocates, not-taken miss does not
    train(mk_pc(1, 3), 1'b1, 32'h0000_1000);
    probe(mk_pc(1, 3), 1'b1, 1'b1, 32'h0000_1000);
    train(mk_pc(2, 3), 1'b0, 32'h0000_2000);
    probe(mk_pc(2, 3), 1'b0, 1'b0, '0);

    // Weak taken down to strong not taken, then saturate
    train(mk_pc(1, 3), 1'b0, 32'h0000_1100);
    train(mk_pc(1, 3), 1'b0, 32'h0000_1100);
    probe(mk_pc(1, 3), 1'b1, 1'b0, 32'h0000_1000);
    train(mk_pc(1, 3), 1'b0, 32'h0000_1100);
    probe(mk_pc(1, 3), 1'b1, 1'b0, 32'h0000_1000);
    // Back up to strong taken, new target on each taken update
    repeat (4) train(mk_pc(1, 3), 1'b1, 32'h0000_1200);
    probe(mk_pc(1, 3), 1'b1, 1'b1, 32'h0000_1200);

    // One more branch than ways in set 5, the first one goes
    for (int i = 0; i <= `BP_WAYS; i++) begin
      train(mk_pc(i + 1, 5), 1'b1, 32'h0000_5000 + 32'(i * 16));
    end
    probe(mk_pc(1, 5), 1'b0, 1'b0, '0);
    for (int i = 1; i <= `BP_WAYS; i++) begin
      probe(mk_pc(i + 1, 5), 1'b1, 1'b1, 32'h0000_5000 + 32'(i * 16));
    end

    // Stall holds while fetch moves on, flush clears even under stall
    step(mk_pc(2, 5), 1'b0, 1'b0);
    step(mk_pc(3, 5), 1'b1, 1'b0);
    step(mk_pc(4, 5), 1'b1, 1'b0);
    expect_id(1'b1, 1'b1, 32'h0000_5010);
    step(mk_pc(4, 5), 1'b1, 1'b1);
    step(mk_pc(4, 5), 1'b0, 1'b0);
    expect_id(1'b0, 1'b0, '0);

    // Random traffic from the pool
    for (int i = 0; i < 3000; i++) begin
      @(posedge clk);
      fetch_pc    <= pool[$urandom_range(0, 11)];
      if_id_stall <= ($urandom_range(0, 7) == 0);
      if_id_flush <= ($urandom_range(0, 15) == 0);
      upd_valid   <= ($urandom_range(0, 2) == 0);
      upd_pc      <= pool[$urandom_range(0, 11)];
      upd_taken   <= ($urandom_range(0, 2) != 0);
      upd_target  <= $urandom;
    end
    step('0, 1'b0, 1'b0);
    wait_checks(n_checked + 2);
    $display("Test OK");
    $finish;
  end

endmodule

/* src.f */
+incdir+hdl
+incdir+verification
hdl/rv_addr_pkg.sv
hdl/bpred_state_pkg.sv
hdl/btb_index.sv
hdl/btb_way.sv
hdl/btb_select.sv
hdl/bpred_if_buffer.sv
hdl/bpred_top.sv
verification/tb_bpred_top.sv

/* Makefile */
# Verilator build for the branch predictor front end

TOP = tb_bpred_top

.PHONY: all lint sim clean

all: sim

# Elaborate everything in the file list and report lint problems
lint:
	verilator --lint-only --timing --assert -f src.f --top-module $(TOP)

# Build and run, a $fatal in the testbench gives a failing exit status
sim:
	verilator --binary --timing --assert -f src.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
